/* logic/heapConfigPkg.sv */
/*
  Heap sizes and the vector types derived from them.
  Every RTL unit and the testbench import this package.
*/
package heapConfigPkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------
  localparam int AddressBits  = 3;                    // Bits in an array number
  localparam int IndexBits    = 2;                    // Bits in an element index
  localparam int DataBits     = 16;                   // Width of a data word
  localparam int ArrayCount   = 8;                    // Arrays held by the heap
  localparam int ArrayLength  = 4;                    // Max elements per array
  localparam int QueueDepth   = 4;                    // FIFO slots, also the initial credits
  localparam int QueuePtrBits = $clog2(QueueDepth);   // FIFO pointer width

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------
  typedef logic [AddressBits-1:0] arrayIdT;           // Array number
  typedef logic [IndexBits-1:0]   elementIndexT;      // Element position
  typedef logic [IndexBits:0]     elementCountT;      // Size, 0 to ArrayLength
  typedef logic [DataBits-1:0]    dataT;              // Data word

endpackage

/* logic/heapCommandPkg.sv */
/*
  Command and response formats of the array heap.
  Opcode and error encodings are shared with the test data file.
*/
package heapCommandPkg;
  import heapConfigPkg::*;

  // Opcodes, numbered as they appear in the test data
  typedef enum logic [3:0] {
    opAlloc    = 4'd0,                                // Allocate an array
    opFree     = 4'd1,                                // Release an array for reuse
    opWrite    = 4'd2,                                // Store one element
    opRead     = 4'd3,                                // Fetch one element
    opSize     = 4'd4,                                // Current element count
    opPush     = 4'd5,                                // Append at the end
    opPop      = 4'd6,                                // Remove from the end
    opAdd      = 4'd7,                                // Add, new value back
    opAddAfter = 4'd8,                                // Add, old value back
    opSubtract = 4'd9,
    opAnd      = 4'd10,
    opOr       = 4'd11,
    opXor      = 4'd12
  } heapOpT;

  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Array never handed out
    errFreed        = 3'd2,                           // Array released earlier
    errOutOfBounds  = 3'd3,                           // Index not below size
    errFull         = 3'd4,                           // Push at ArrayLength
    errEmpty        = 3'd5,                           // Pop at size zero
    errOutOfMemory  = 3'd6                            // No array left to allocate
  } heapErrorT;

  typedef struct packed {
    heapOpT       op;
    arrayIdT      array;
    elementIndexT index;
    dataT         data;
  } heapCommandT;                                     // 25 bits

  typedef struct packed {
    dataT      data;
    heapErrorT error;
  } heapResponseT;                                    // 19 bits

endpackage

/* logic/commandQueue.sv */
/*
  Command FIFO in front of the execution stage. Pops one command per
  cycle into the issue register and hands a credit back with each pop.
*/
`timescale 1ns/1ps

module commandQueue
  import heapConfigPkg::*;
  import heapCommandPkg::*;
(
  input  logic        clock,
  input  logic        resetN,
  input  logic        cmdValid,
  input  heapCommandT command,
  output logic        creditReturn,
  output logic        issueValid,
  output heapCommandT issued
);

  heapCommandT              slots [QueueDepth];       // FIFO storage
  logic [QueuePtrBits-1:0]  writePtr;                 // Next free slot
  logic [QueuePtrBits-1:0]  readPtr;                  // Oldest command
  logic [QueuePtrBits:0]    fill;                     // Commands waiting
  logic                     popNow;

  assign popNow       = fill != '0;                   // Drain whenever anything waits
  assign creditReturn = issueValid;                   // One credit per command issued

  // ----------------------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      writePtr   <= '0;
      readPtr    <= '0;
      fill       <= '0;
      issueValid <= 1'b0;
    end else begin
      if (cmdValid) writePtr <= writePtr + 1'b1;      // Depth is a power of two, wraps
      if (popNow) readPtr <= readPtr + 1'b1;
      case ({cmdValid, popNow})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;                        // Both or neither
      endcase
      issueValid <= popNow;
    end
  end

  // Slot contents and issue register
  always_ff @(posedge clock) begin
    if (cmdValid) slots[writePtr] <= command;
    if (popNow) issued <= slots[readPtr];             // Never the slot being written
  end

  // Requester holds no credit while all slots are taken
  creditCheck: assert property (@(posedge clock) disable iff (!resetN)
    cmdValid |-> fill != QueueDepth)
    else $error("command accepted with the FIFO full");

endmodule

/* logic/allocationTracker.sv */
/*
  Tracks which arrays are live. Alloc takes the most recently freed
  array first, then a never used one from the fresh counter.
*/
`timescale 1ns/1ps

module allocationTracker
  import heapConfigPkg::*;
  import heapCommandPkg::*;
(
  input  logic        clock,
  input  logic        resetN,
  input  logic        issueValid,
  input  heapCommandT issued,
  output logic        arrayLive,
  output heapErrorT   trackerError,
  output logic        allocGrant,
  output arrayIdT     allocArray
);

  logic [ArrayCount-1:0] live;                        // One bit per allocated array
  logic [AddressBits:0]  freshNext;                   // Arrays ever handed out
  logic [AddressBits:0]  stackTop;                    // Entries on the freed stack
  arrayIdT               freedStack [ArrayCount];     // Freed arrays, newest on top
  logic                  neverUsed;
  logic                  fromStack;
  logic                  outOfMemory;
  logic                  freeNow;

  assign neverUsed   = {1'b0, issued.array} >= freshNext;
  assign fromStack   = stackTop != '0;
  assign outOfMemory = !fromStack && (freshNext == ArrayCount);
  assign allocArray  = fromStack ? freedStack[arrayIdT'(stackTop - 1'b1)]
                                 : freshNext[AddressBits-1:0];
  assign allocGrant  = issueValid && (issued.op == opAlloc) && !outOfMemory;
  assign freeNow     = arrayLive && (issued.op == opFree);

  // ----------------------------------------------------------------------
  // Classify the issued array
  // ----------------------------------------------------------------------
  always_comb begin
    trackerError = errNone;
    arrayLive    = 1'b0;
    if (issued.op == opAlloc) begin
      if (outOfMemory) trackerError = errOutOfMemory; // Array field ignored
    end else if (neverUsed) begin
      trackerError = errNotAllocated;
    end else if (!live[issued.array]) begin
      trackerError = errFreed;                        // Covers a second Free too
    end else begin
      arrayLive = issueValid;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      live      <= '0;
      freshNext <= '0;
      stackTop  <= '0;
    end else if (allocGrant) begin
      live[allocArray] <= 1'b1;
      if (fromStack) stackTop <= stackTop - 1'b1;     // Reuse newest freed
      else freshNext <= freshNext + 1'b1;
    end else if (freeNow) begin
      live[issued.array] <= 1'b0;
      stackTop           <= stackTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (freeNow) freedStack[arrayIdT'(stackTop)] <= issued.array;  // A live array exists, so room
  end

  stackBound: assert property (@(posedge clock) disable iff (!resetN)
    stackTop <= ArrayCount)
    else $error("freed stack overflow");

endmodule

/* logic/elementStore.sv */
/*
  Contents and sizes of all arrays. Executes the element operations on
  a live array within the issue cycle and commits on the next edge.
*/
`timescale 1ns/1ps

module elementStore
  import heapConfigPkg::*;
  import heapCommandPkg::*;
(
  input  logic        clock,
  input  logic        resetN,
  input  logic        issueValid,
  input  heapCommandT issued,
  input  logic        arrayLive,
  input  logic        allocGrant,
  input  arrayIdT     allocArray,
  output dataT        storeData,
  output heapErrorT   storeError
);

  dataT         contents [ArrayCount][ArrayLength];   // Element words
  elementCountT sizes [ArrayCount];                   // Element count per array
  elementCountT size;                                 // Size of the issued array
  elementCountT newSize;
  elementIndexT slot;                                 // Element read and written
  dataT         element;
  dataT         result;                               // Value written back
  logic         inBounds;
  logic         writeEnable;

  assign size     = sizes[issued.array];
  assign inBounds = {1'b0, issued.index} < size;
  assign element  = contents[issued.array][slot];

  always_comb begin
    case (issued.op)
      opPush:  slot = elementIndexT'(size);           // Below ArrayLength unless full
      opPop:   slot = elementIndexT'(size - 1'b1);    // Top element
      default: slot = issued.index;
    endcase
  end

  // ----------------------------------------------------------------------
  // Operation decode
  // ----------------------------------------------------------------------
  always_comb begin
    storeError  = errNone;
    storeData   = '0;
    result      = issued.data;
    writeEnable = 1'b0;
    newSize     = size;
    if (arrayLive) begin                              // Alloc and dead arrays skip
      case (issued.op)
        opWrite: begin
          writeEnable = 1'b1;
          storeData   = issued.data;
          if (!inBounds) newSize = elementCountT'(issued.index) + 1'b1;  // Grow to fit
        end
        opRead: begin
          if (!inBounds) storeError = errOutOfBounds;
          else storeData = element;
        end
        opSize: storeData = dataT'(size);
        opPush: begin
          if (size == ArrayLength) storeError = errFull;
          else begin
            writeEnable = 1'b1;
            newSize     = size + 1'b1;
          end
        end
        opPop: begin
          if (size == '0) storeError = errEmpty;
          else begin
            storeData = element;
            newSize   = size - 1'b1;
          end
        end
        opAdd, opAddAfter, opSubtract, opAnd, opOr, opXor: begin
          if (!inBounds) storeError = errOutOfBounds;
          else begin
            case (issued.op)
              opSubtract: result = element - issued.data;   // Wraps at 16 bits
              opAnd:      result = element & issued.data;
              opOr:       result = element | issued.data;
              opXor:      result = element ^ issued.data;
              default:    result = element + issued.data;   // Add and AddAfter
            endcase
            writeEnable = 1'b1;
            storeData   = (issued.op == opAddAfter) ? element : result;
          end
        end
        default: storeData = '0;                      // Free carries no data
      endcase
    end
  end

  // Sizes, cleared on reset and on a fresh grant
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < ArrayCount; i++) sizes[i] <= '0;
    end else if (allocGrant) begin
      sizes[allocArray] <= '0;
    end else if (arrayLive && storeError == errNone) begin
      sizes[issued.array] <= newSize;
    end
  end

  always_ff @(posedge clock) begin
    if (writeEnable) contents[issued.array][slot] <= result;
  end

  sizeBound: assert property (@(posedge clock) disable iff (!resetN)
    issueValid |-> size <= ArrayLength)
    else $error("array size beyond ArrayLength");

endmodule

/* logic/responseRegister.sv */
/*
  Merges the tracker and store results into one response and
  registers it. Tracker errors win over store errors.
*/
`timescale 1ns/1ps

module responseRegister
  import heapConfigPkg::*;
  import heapCommandPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         issueValid,
  input  heapCommandT  issued,
  input  heapErrorT    trackerError,
  input  arrayIdT      allocArray,
  input  dataT         storeData,
  input  heapErrorT    storeError,
  output logic         respValid,
  output heapResponseT response
);

  heapErrorT finalError;
  dataT      finalData;

  always_comb begin
    finalError = (trackerError != errNone) ? trackerError : storeError;
    if (finalError != errNone) finalData = '0;        // Errors carry no data
    else if (issued.op == opAlloc) finalData = dataT'(allocArray);
    else finalData = storeData;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) respValid <= 1'b0;
    else respValid <= issueValid;                     // One response per issue
  end

  always_ff @(posedge clock) begin
    if (issueValid) begin
      response.data  <= finalData;
      response.error <= finalError;
    end
  end

endmodule

/* logic/arrayHeap.sv */
/*
  Array heap top level. Commands enter under credit flow control and
  responses leave in order, two cycles after an idle FIFO accepts one.
*/
`timescale 1ns/1ps

module arrayHeap
  import heapConfigPkg::*;
  import heapCommandPkg::*;
(
  input  logic         clock,
  input  logic         resetN,
  input  logic         cmdValid,
  input  heapCommandT  command,
  output logic         creditReturn,
  output logic         respValid,
  output heapResponseT response
);

  // ----------------------------------------------------------------------
  // Issue stage wires
  // ----------------------------------------------------------------------
  logic        issueValid;
  heapCommandT issued;
  logic        arrayLive;                             // Issued array is allocated
  heapErrorT   trackerError;
  logic        allocGrant;
  arrayIdT     allocArray;                            // Array handed out by Alloc
  dataT        storeData;
  heapErrorT   storeError;

  commandQueue queue (
    .clock, .resetN, .cmdValid, .command,
    .creditReturn, .issueValid, .issued
  );

  allocationTracker tracker (
    .clock, .resetN, .issueValid, .issued,
    .arrayLive, .trackerError, .allocGrant, .allocArray
  );

  elementStore store (
    .clock, .resetN, .issueValid, .issued,
    .arrayLive, .allocGrant, .allocArray, .storeData, .storeError
  );

  responseRegister responder (
    .clock, .resetN, .issueValid, .issued, .trackerError,
    .allocArray, .storeData, .storeError, .respValid, .response
  );

endmodule

/* verification/arrayHeapTb.sv */
/*
  Testbench for the array heap. Replays the command list of the test data
  file under credit flow control and checks every response in order.
*/
`timescale 1ns/1ps

module arrayHeapTb
  import heapConfigPkg::*;
  import heapCommandPkg::*;
();

  localparam int MaxLines    = 64;                    // Room in the vector memory
  localparam int MaxGap      = 3;                     // Longest random idle gap
  localparam int BurstStart  = 17;                    // From here commands go back to back
  localparam int ResetCycles = 16;
  localparam int Margin      = 50;                    // Spare watchdog cycles

  logic         clock = 1'b0;
  logic         resetN;
  logic         cmdValid;
  heapCommandT  command;
  logic         creditReturn;
  logic         respValid;
  heapResponseT response;

  logic [47:0]  vectors [MaxLines];                   // op, array, index, data, expected
  int           lineCount = 0;
  int           pending [$];                          // Vectors awaiting a response
  int           credits = QueueDepth;                 // Requester's credit count
  int           lowestCredits = QueueDepth;
  int           received = 0;
  int           checks = 0;
  int           errors = 0;

  arrayHeap i_dut (
    .clock, .resetN, .cmdValid, .command,
    .creditReturn, .respValid, .response
  );

  always #2 clock = ~clock;                           // 4 ns period

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
    end else begin
      $display("passed %s", name);
    end
  endtask

  // ----------------------------------------------------------------------
  // Credits and responses, sampled on the rising edge
  // ----------------------------------------------------------------------
  always @(posedge clock) begin
    if (!resetN) credits <= QueueDepth;
    else credits <= credits - int'(cmdValid) + int'(creditReturn);  // Spend and refund
  end

  always @(posedge clock) begin : responseMonitor
    int          line;
    heapOpT      op;
    logic [47:0] v;
    if (resetN && respValid) begin
      if (pending.size() == 0) begin
        errors++;
        $display("A response arrived with no command outstanding");
      end else begin
        line = pending.pop_front();                   // Oldest command first
        v    = vectors[line];
        op   = heapOpT'(v[47:44]);
        checkValue($sformatf("vector %0d %s", line + 1, op.name()),
                   {12'h0, v[19:4], v[3:0]},          // Data then error
                   {12'h0, response.data, 1'b0, response.error});
        received++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Command driver
  // ----------------------------------------------------------------------
  initial begin : mainSequence
    logic [47:0] v;
    int          i;
    int          gap;
    int          available;
    void'($urandom(12));
    resetN   = 1'b0;
    cmdValid = 1'b0;
    command  = '0;
    $readmemh("verification/arrayHeapTestdata.mem", vectors);
    while (lineCount < MaxLines && vectors[lineCount][47:44] !== 4'hf) lineCount++;
    if (lineCount == MaxLines) begin
      $display("The test data file could not be read or has no end marker");
      $display("TEST RESULT: FAIL");
      $finish;
    end
    repeat (ResetCycles) @(posedge clock);
    resetN <= 1'b1;
    for (i = 0; i < lineCount; i++) begin
      gap = (i < BurstStart) ? int'($urandom % (MaxGap + 1)) : 0;
      repeat (gap) begin
        @(posedge clock);
        cmdValid <= 1'b0;                             // Idle cycle
      end
      @(posedge clock);
      available = credits - int'(cmdValid);           // Command on the wire still counts
      while (available == 0) begin
        cmdValid <= 1'b0;                             // Stall until a credit returns
        @(posedge clock);
        available = credits - int'(cmdValid);
      end
      if (available - 1 < lowestCredits) lowestCredits = available - 1;
      v = vectors[i];
      cmdValid <= 1'b1;
      command  <= {v[47:44], v[42:40], v[37:36], v[35:20]};
      pending.push_back(i);
    end
    @(posedge clock);
    cmdValid <= 1'b0;
    wait (received == lineCount);
    repeat (3) @(posedge clock);                      // Last credit comes home
    checkValue("credits restored", QueueDepth, credits);
    checkValue("credits used up in burst", 0, lowestCredits);  // Back to back drains all
    $display("%0d checks, %0d errors, lowest credit count %0d",
             checks, errors, lowestCredits);
    if (errors == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

  // Bound on the whole run, from the vector count
  initial begin : watchdog
    wait (lineCount > 0);
    repeat (ResetCycles + lineCount * (MaxGap + 4) + Margin) @(posedge clock);
    $display("Watchdog expired with %0d responses missing", lineCount - received);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verification/arrayHeapTestdata.mem */
// op_array_index_data_expecteddata_expectederror, all hex, one command per line
// op f marks the end of the list
3_5_0_0000_0000_1
0_0_0_0000_0000_0
0_0_0_0000_0001_0
0_0_0_0000_0002_0
1_1_0_0000_0000_0
2_1_0_1234_0000_2
1_1_0_0000_0000_2
0_0_0_0000_0001_0
2_0_2_00a5_00a5_0
4_0_0_0000_0003_0
3_0_3_0000_0000_3
7_0_2_ff60_0005_0
8_0_2_0003_0005_0
9_0_2_0009_ffff_0
a_0_2_0f0f_0f0f_0
b_0_2_f000_ff0f_0
c_0_2_00ff_fff0_0
6_2_0_0000_0000_5
5_2_0_0011_0000_0
5_2_0_0022_0000_0
5_2_0_0033_0000_0
5_2_0_0044_0000_0
5_2_0_0055_0000_4
6_2_0_0000_0044_0
6_2_0_0000_0033_0
6_2_0_0000_0022_0
6_2_0_0000_0011_0
0_0_0_0000_0003_0
0_0_0_0000_0004_0
0_0_0_0000_0005_0
0_0_0_0000_0006_0
0_0_0_0000_0007_0
0_0_0_0000_0000_6
f_0_0_0000_0000_0

/* all.f */
logic/heapConfigPkg.sv
logic/heapCommandPkg.sv
logic/commandQueue.sv
logic/allocationTracker.sv
logic/elementStore.sv
logic/responseRegister.sv
logic/arrayHeap.sv
verification/arrayHeapTb.sv

/* run.sh */
#!/bin/sh
# Build the array heap testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module arrayHeapTb \
  -o arrayHeapSim > build.log 2>&1 \
  && ./obj_dir/arrayHeapSim > sim.log 2>&1 \
  || echo "TEST RESULT: FAIL" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1 || exit 0
